//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_control_path
FILELIST = project.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/alu_instr_decoder.sv
`timescale 1ns/1ps

module alu_instr_decoder
  import ctrl_isa_pkg::*, ctrl_sig_pkg::*;
(
  input  instr_t       instr,
  output alu_ctrl_t    alu_ctrl,
  output branch_ctrl_t branch_ctrl,
  output logic         invalid
);

  logic [word_w-1:0] imm_zext;
  logic [word_w-1:0] imm_sext;

  assign imm_zext = {{(word_w-imm_w){1'b0}}, instr.imm};
  assign imm_sext = {{(word_w-imm_w){instr.imm[imm_w-1]}}, instr.imm};

  always_comb begin
    alu_ctrl    = '0;
    branch_ctrl = '0;
    invalid     = 1'b0;

    case (instr.iclass)
      ic_arith: begin
        alu_ctrl.opcode    = instr.sub;
        alu_ctrl.form      = instr.form;
        alu_ctrl.a_select  = instr.f_a;
        alu_ctrl.b_select  = instr.f_b;
        alu_ctrl.y1_select = instr.f_y1;
        // immediate form takes the constant as operand
        alu_ctrl.const_c   = instr.form;
        alu_ctrl.constant  = imm_zext;
        alu_ctrl.reg_write = rw_alu;
        invalid            = instr.sub > alu_op_max;
      end

      ic_jump: begin
        branch_ctrl.compare_op = instr.sub;
        branch_ctrl.condition  = instr.form;
        // operands for the compare, offset for the target
        alu_ctrl.a_select      = instr.f_a;
        alu_ctrl.b_select      = instr.f_b;
        alu_ctrl.constant      = imm_sext;
        alu_ctrl.reg_write     = rw_none;
        invalid                = instr.sub > cmp_op_max;
      end

      // load/store and special words belong to the other decoder
      default: begin
        invalid = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/control_fsm.sv
`timescale 1ns/1ps

module control_fsm
  import ctrl_isa_pkg::*, ctrl_sig_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         go,
  input  logic         halt,
  input  instr_class_t instr_class,
  input  logic         is_ld,
  input  logic         is_st,
  input  logic         halt_req,
  input  logic         invalid,
  input  logic         wait_instr,
  input  logic         wait_data,
  input  logic         instr_segv,
  input  logic         data_segv,
  output ctrl_state_t  state
);

  ctrl_state_t state_next;
  logic        is_mem;

  assign is_mem = instr_class == ic_ls;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= halt_s;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;

    case (state)
      halt_s: begin
        if (go) begin
          state_next = read_ins;
        end
      end

      read_ins: begin
        // a fetch fault wins over a pending wait
        if (instr_segv) begin
          state_next = trap_s;
        end else if (!wait_instr) begin
          state_next = do_s;
        end
      end

      do_s: begin
        if (invalid) begin
          state_next = trap_s;
        end else if (is_mem && is_ld) begin
          state_next = wait_load;
        end else if (is_mem && is_st) begin
          state_next = wait_store;
        end else if (halt_req || halt) begin
          state_next = halt_s;
        end else begin
          state_next = read_ins;
        end
      end

      wait_load, wait_store: begin
        if (data_segv) begin
          state_next = trap_s;
        end else if (!wait_data) begin
          state_next = halt ? halt_s : read_ins;
        end
      end

      // only reset leaves the trap
      trap_s: begin
        state_next = trap_s;
      end

      default: begin
        state_next = halt_s;
      end
    endcase
  end

endmodule

//--- hw/control_path.sv
`timescale 1ns/1ps

module control_path
  import ctrl_isa_pkg::*, ctrl_sig_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         go,
  input  logic         halt,
  input  instr_t       instruction,
  input  logic         wait_instr,
  input  logic         wait_data,
  input  logic         instr_segv,
  input  logic         data_segv,
  output logic         exec,
  output logic         pc_inc,
  output logic         jump,
  output logic         trapped,
  output alu_ctrl_t    alu_ctrl,
  output branch_ctrl_t branch_ctrl,
  output mem_ctrl_t    mem_ctrl
);

  instr_t       instr_reg;
  ctrl_state_t  state;

  alu_ctrl_t    arith_alu;
  branch_ctrl_t arith_branch;
  logic         arith_invalid;

  alu_ctrl_t    mem_alu;
  mem_ctrl_t    mem_dec;
  logic         mem_halt_req;
  logic         mem_invalid;

  logic         sel_arith;
  logic         invalid;
  logic         valid_exec;
  logic         is_jump;

  // fetched word, captured on the edge where the memory stops waiting
  always_ff @(posedge clk) begin
    if (state == read_ins && !wait_instr) begin
      instr_reg <= instruction;
    end
  end

  alu_instr_decoder alu_instr_decoder_i (
    .instr       (instr_reg),
    .alu_ctrl    (arith_alu),
    .branch_ctrl (arith_branch),
    .invalid     (arith_invalid)
  );

  mem_instr_decoder mem_instr_decoder_i (
    .instr    (instr_reg),
    .mem_ctrl (mem_dec),
    .alu_ctrl (mem_alu),
    .halt_req (mem_halt_req),
    .invalid  (mem_invalid)
  );

  // bit 31 splits arith/jump from load-store/special
  assign sel_arith = instr_reg.iclass[1];
  assign invalid   = sel_arith ? arith_invalid : mem_invalid;

  control_fsm control_fsm_i (
    .clk         (clk),
    .reset       (reset),
    .go          (go),
    .halt        (halt),
    .instr_class (instr_reg.iclass),
    .is_ld       (instr_reg.sub[sub_ld_bit]),
    .is_st       (instr_reg.sub[sub_st_bit]),
    .halt_req    (mem_halt_req),
    .invalid     (invalid),
    .wait_instr  (wait_instr),
    .wait_data   (wait_data),
    .instr_segv  (instr_segv),
    .data_segv   (data_segv),
    .state       (state)
  );

  assign valid_exec = state == do_s && !invalid;
  assign is_jump    = instr_reg.iclass == ic_jump;

  assign exec    = valid_exec;
  assign pc_inc  = valid_exec && !is_jump;
  assign jump    = valid_exec && is_jump;
  assign trapped = state == trap_s;

  always_comb begin
    alu_ctrl = sel_arith ? arith_alu : mem_alu;
    // no register write outside a good execute cycle
    if (!valid_exec) begin
      alu_ctrl.reg_write = rw_none;
    end
  end

  assign branch_ctrl = arith_branch;

  always_comb begin
    mem_ctrl    = mem_dec;
    // ld/st held from execute through the matching wait
    mem_ctrl.ld = mem_dec.ld && (valid_exec || state == wait_load);
    mem_ctrl.st = mem_dec.st && (valid_exec || state == wait_store);
  end

endmodule

//--- hw/ctrl_isa_pkg.sv
package ctrl_isa_pkg;

  // instruction word layout, msb first
  // [31:30] class, [29:27] sub, [26] form, [25:22] y1, [21:18] a, [17:14] b, [13:0] imm
  localparam int class_w   = 2;
  localparam int sub_w     = 3;
  localparam int reg_sel_w = 4;
  localparam int imm_w     = 14;

  // class codes from bits 31:30
  localparam logic [class_w-1:0] class_ls      = 2'b00;
  localparam logic [class_w-1:0] class_special = 2'b01;
  localparam logic [class_w-1:0] class_arith   = 2'b10;
  localparam logic [class_w-1:0] class_jump    = 2'b11;

  typedef enum logic [class_w-1:0] {
    ic_ls      = class_ls,
    ic_special = class_special,
    ic_arith   = class_arith,
    ic_jump    = class_jump
  } instr_class_t;

  // highest legal opcode and compare code
  localparam logic [sub_w-1:0] alu_op_max = 3'd5;
  localparam logic [sub_w-1:0] cmp_op_max = 3'd5;

  // special sub-codes
  localparam logic [sub_w-1:0] sp_nop  = 3'b000;
  localparam logic [sub_w-1:0] sp_halt = 3'b001;

  // bit positions of store and load inside the sub field
  localparam int sub_st_bit = 2;
  localparam int sub_ld_bit = 1;

  // for load/store words, f_y1 carries the register address
  // and f_a the memory base select
  typedef struct packed {
    instr_class_t         iclass;
    logic [sub_w-1:0]     sub;
    logic                 form;
    logic [reg_sel_w-1:0] f_y1;
    logic [reg_sel_w-1:0] f_a;
    logic [reg_sel_w-1:0] f_b;
    logic [imm_w-1:0]     imm;
  } instr_t;

endpackage

//--- hw/ctrl_sig_pkg.sv
package ctrl_sig_pkg;

  import ctrl_isa_pkg::*;

  localparam int word_w = 32;

  // reg_write encodings
  localparam logic [1:0] rw_none = 2'b00;
  localparam logic [1:0] rw_alu  = 2'b01;
  localparam logic [1:0] rw_mem  = 2'b10;

  typedef struct packed {
    logic [sub_w-1:0]     opcode;
    logic                 form;
    logic [reg_sel_w-1:0] a_select;
    logic [reg_sel_w-1:0] b_select;
    logic [reg_sel_w-1:0] y1_select;
    logic                 const_c;
    logic [word_w-1:0]    constant;
    logic [1:0]           reg_write;
  } alu_ctrl_t;

  typedef struct packed {
    logic                 ld;
    logic                 st;
    logic [reg_sel_w-1:0] reg_addr;
    logic [reg_sel_w-1:0] mem_loca_addr;
  } mem_ctrl_t;

  typedef struct packed {
    logic [sub_w-1:0] compare_op;
    logic             condition;
  } branch_ctrl_t;

  typedef enum logic [2:0] {
    halt_s,
    read_ins,
    do_s,
    wait_load,
    wait_store,
    trap_s
  } ctrl_state_t;

endpackage

//--- hw/mem_instr_decoder.sv
`timescale 1ns/1ps

module mem_instr_decoder
  import ctrl_isa_pkg::*, ctrl_sig_pkg::*;
(
  input  instr_t    instr,
  output mem_ctrl_t mem_ctrl,
  output alu_ctrl_t alu_ctrl,
  output logic      halt_req,
  output logic      invalid
);

  logic st_bit;
  logic ld_bit;

  assign st_bit = instr.sub[sub_st_bit];
  assign ld_bit = instr.sub[sub_ld_bit];

  always_comb begin
    mem_ctrl = '0;
    alu_ctrl = '0;
    halt_req = 1'b0;
    invalid  = 1'b0;

    case (instr.iclass)
      ic_ls: begin
        mem_ctrl.ld            = ld_bit;
        mem_ctrl.st            = st_bit;
        mem_ctrl.reg_addr      = instr.f_y1;
        mem_ctrl.mem_loca_addr = instr.f_a;
        // address = base + offset through the alu adder
        alu_ctrl.opcode        = 3'd0;
        alu_ctrl.form          = 1'b1;
        alu_ctrl.a_select      = instr.f_a;
        alu_ctrl.const_c       = 1'b1;
        alu_ctrl.constant      = {{(word_w-imm_w){1'b0}}, instr.imm};
        alu_ctrl.reg_write     = ld_bit ? rw_mem : rw_none;
        // exactly one of load and store
        invalid                = ld_bit == st_bit;
      end

      ic_special: begin
        case (instr.sub)
          sp_nop:  halt_req = 1'b0;
          sp_halt: halt_req = 1'b1;
          default: invalid  = 1'b1;
        endcase
      end

      default: begin
        invalid = 1'b0;
      end
    endcase
  end

endmodule

//--- project.f
hw/ctrl_isa_pkg.sv
hw/ctrl_sig_pkg.sv
hw/alu_instr_decoder.sv
hw/mem_instr_decoder.sv
hw/control_fsm.sv
hw/control_path.sv
sim/control_path_props.sv
sim/tb_control_path.sv

//--- sim/control_path_props.sv
`timescale 1ns/1ps

module control_path_props
  import ctrl_sig_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        exec,
  input logic        pc_inc,
  input logic        jump,
  input logic        trapped,
  input logic        wait_instr,
  input ctrl_state_t state
);

  // pc strobes last a single cycle
  strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
    (pc_inc || jump) |=> !(pc_inc || jump))
    else $error("pc_inc or jump high for two cycles in a row");

  // execute only follows a fetch that saw no wait
  exec_after_fetch: assert property (@(posedge clk) disable iff (reset)
    exec |-> $past(state == read_ins && !wait_instr))
    else $error("exec without a completed fetch in the previous cycle");

  // only reset leaves the trap
  trap_sticky: assert property (@(posedge clk) disable iff (reset) trapped |=> trapped)
    else $error("trapped fell without reset");

endmodule

bind control_path control_path_props control_path_props_i (
  .clk        (clk),
  .reset      (reset),
  .exec       (exec),
  .pc_inc     (pc_inc),
  .jump       (jump),
  .trapped    (trapped),
  .wait_instr (wait_instr),
  .state      (state)
);

//--- sim/tb_control_path.sv
`timescale 1ns/1ps

module tb_control_path
  import ctrl_isa_pkg::*, ctrl_sig_pkg::*;
();

  localparam int          num_words  = 400;
  localparam int          wait_limit = 16;
  localparam logic [31:0] nop_word   = 32'h4000_0000;

  logic         clk;
  logic         reset;
  logic         go;
  logic         halt;
  instr_t       instruction;
  logic         wait_instr;
  logic         wait_data;
  logic         instr_segv;
  logic         data_segv;
  logic         exec;
  logic         pc_inc;
  logic         jump;
  logic         trapped;
  alu_ctrl_t    alu_ctrl;
  branch_ctrl_t branch_ctrl;
  mem_ctrl_t    mem_ctrl;

  integer seed;

  control_path control_path_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_alu(input alu_ctrl_t got, input alu_ctrl_t exp);
    if (got !== exp) begin
      $display("ERROR alu_ctrl exp %h got %h", exp, got);
      abort_run();
    end
  endtask

  task automatic check_branch(input branch_ctrl_t got, input branch_ctrl_t exp);
    if (got !== exp) begin
      $display("ERROR branch_ctrl exp %h got %h", exp, got);
      abort_run();
    end
  endtask

  task automatic check_mem(input mem_ctrl_t got, input mem_ctrl_t exp);
    if (got !== exp) begin
      $display("ERROR mem_ctrl exp %h got %h", exp, got);
      abort_run();
    end
  endtask

  task automatic check_strobes(input logic e_exec, input logic e_pc, input logic e_jump,
                               input logic e_trap);
    if ({exec, pc_inc, jump, trapped} !== {e_exec, e_pc, e_jump, e_trap}) begin
      $display("ERROR {exec,pc_inc,jump,trapped} exp %h got %h",
               {e_exec, e_pc, e_jump, e_trap}, {exec, pc_inc, jump, trapped});
      abort_run();
    end
  endtask

  // reference decode straight from the bit layout of the word
  function automatic void model_decode(
    input  logic [31:0]  w,
    output alu_ctrl_t    a,
    output branch_ctrl_t b,
    output mem_ctrl_t    m,
    output logic         bad,
    output logic         hreq
  );
    a    = '0;
    b    = '0;
    m    = '0;
    bad  = 1'b0;
    hreq = 1'b0;
    case (w[31:30])
      2'b00: begin
        m.st            = w[29];
        m.ld            = w[28];
        m.reg_addr      = w[25:22];
        m.mem_loca_addr = w[21:18];
        // base + offset on the alu adder
        a.form          = 1'b1;
        a.a_select      = w[21:18];
        a.const_c       = 1'b1;
        a.constant      = {18'd0, w[13:0]};
        a.reg_write     = w[28] ? 2'b10 : 2'b00;
        bad             = w[29] == w[28];
      end
      2'b01: begin
        hreq = w[29:27] == 3'b001;
        bad  = w[29:27] > 3'b001;
      end
      2'b10: begin
        a.opcode    = w[29:27];
        a.form      = w[26];
        a.y1_select = w[25:22];
        a.a_select  = w[21:18];
        a.b_select  = w[17:14];
        a.const_c   = w[26];
        a.constant  = {18'd0, w[13:0]};
        a.reg_write = 2'b01;
        bad         = w[29:27] > 3'd5;
      end
      default: begin
        b.compare_op = w[29:27];
        b.condition  = w[26];
        a.a_select   = w[21:18];
        a.b_select   = w[17:14];
        a.constant   = {{18{w[13]}}, w[13:0]};
        bad          = w[29:27] > 3'd5;
      end
    endcase
  endfunction

  // mostly legal words over all classes, about one in sixteen illegal
  task automatic make_word(output logic [31:0] w);
    logic [31:0] r;
    logic        bad;
    logic [2:0]  sub;

    w   = $random(seed);
    r   = $random(seed);
    bad = r[7:4] == 4'd0;
    sub = r[12:10];
    if (sub > 3'd5) sub = sub - 3'd3;
    w[31:30] = r[1:0];
    case (r[1:0])
      2'b00:   w[29:28] = bad ? {r[8], r[8]} : {r[9], !r[9]};
      2'b01:   w[29:27] = bad ? (3'b010 | {r[12], 1'b0, r[11]}) : {2'b00, r[13:11] == 3'd0};
      default: w[29:27] = bad ? {2'b11, r[9]} : sub;
    endcase
  endtask

  task automatic apply_reset();
    reset       = 1'b1;
    go          = 1'b0;
    halt        = 1'b0;
    instruction = '0;
    wait_instr  = 1'b1;
    wait_data   = 1'b0;
    instr_segv  = 1'b0;
    data_segv   = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // one go pulse, leaves the machine in read_ins
  task automatic start_run();
    wait_instr = 1'b1;
    go         = 1'b1;
    @(negedge clk);
    go = 1'b0;
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  // halted machine must ignore a ready nop until go
  task automatic idle_until_go();
    int k;

    for (k = 0; k < 3; k++) begin
      wait_instr  = 1'b0;
      instruction = nop_word;
      @(negedge clk);
      check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
    end
    start_run();
  endtask

  task automatic wait_for_trap(input string cause);
    int n;

    n = 0;
    while (!trapped) begin
      check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
      @(negedge clk);
      instr_segv = 1'b0;
      data_segv  = 1'b0;
      n = n + 1;
      if (n >= wait_limit) begin
        $display("timeout waiting for trapped after %s", cause);
        abort_run();
      end
    end
    // trapped is sticky until reset
    repeat (3) begin
      check_strobes(1'b0, 1'b0, 1'b0, 1'b1);
      @(negedge clk);
    end
    check_strobes(1'b0, 1'b0, 1'b0, 1'b1);
    apply_reset();
    start_run();
  endtask

  // called right after a falling edge with the machine in read_ins
  task automatic run_one();
    logic [31:0]  w;
    logic [31:0]  r;
    alu_ctrl_t    ea;
    branch_ctrl_t eb;
    mem_ctrl_t    em;
    logic         ebad;
    logic         ehreq;
    logic         is_jmp;
    logic         use_halt;
    int           fetch_wait;
    int           data_wait;
    int           n;

    make_word(w);
    model_decode(w, ea, eb, em, ebad, ehreq);
    r          = $random(seed);
    fetch_wait = {30'd0, r[1:0]};
    data_wait  = {30'd0, r[3:2]};
    use_halt   = r[18:16] == 3'd0;
    is_jmp     = w[31:30] == 2'b11;

    for (n = 0; n < fetch_wait; n++) begin
      wait_instr  = 1'b1;
      instruction = $random(seed);
      @(negedge clk);
      check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
    end
    if (r[9:4] == 6'd0) begin
      instr_segv = 1'b1;
      wait_for_trap("instr_segv");
      return;
    end
    wait_instr  = 1'b0;
    instruction = w;
    if (ebad) begin
      @(negedge clk);
      wait_instr = 1'b1;
      wait_for_trap("an invalid word");
      return;
    end

    n = 0;
    while (!exec) begin
      @(negedge clk);
      wait_instr = 1'b1;
      n = n + 1;
      if (n >= wait_limit) begin
        $display("timeout waiting for exec after the fetch");
        abort_run();
      end
    end
    if (n != 1) begin
      $display("exec came %0d cycles after the fetch edge instead of 1", n);
      abort_run();
    end
    check_strobes(1'b1, !is_jmp, is_jmp, 1'b0);
    check_alu(alu_ctrl, ea);
    check_branch(branch_ctrl, eb);
    check_mem(mem_ctrl, em);

    if (em.ld || em.st) begin
      wait_data = 1'b1;
      for (n = 1; n <= data_wait + 1; n++) begin
        @(negedge clk);
        check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
        check_mem(mem_ctrl, em);
        wait_data = n <= data_wait;
        if (r[15:10] == 6'd0) begin
          data_segv = 1'b1;
          wait_for_trap("data_segv");
          return;
        end
      end
    end
    // halt seen on the execute cycle or on the last data wait cycle
    halt = use_halt;
    @(negedge clk);
    halt      = 1'b0;
    wait_data = 1'b0;
    check_strobes(1'b0, 1'b0, 1'b0, 1'b0);
    if (mem_ctrl.ld || mem_ctrl.st) begin
      $display("ld/st still high after the data wait ended");
      abort_run();
    end
    if (ehreq || use_halt) begin
      idle_until_go();
    end
  endtask

  initial begin
    int i;

    seed = 51053;
    apply_reset();
    start_run();
    for (i = 0; i < num_words; i++) begin
      run_one();
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
